/* include/memStage_cfg.svh */
// Memory stage configuration.
// Data path width and the size of the data RAM in words.

`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// Width of a data word.
`define DATA_WIDTH 32

// Word address bits of the data RAM, 64 words.
`define RAM_ADDR_BITS 6

`endif

/* logic/dataRam.sv */
// Data RAM.
// Word-addressed synchronous RAM with byte write enables and a registered read.

`timescale 1ns/100ps
`default_nettype none

`include "memStage_cfg.svh"

module dataRam (
    input  logic                      clk,
    input  logic                      readEn,
    input  logic [`RAM_ADDR_BITS-1:0] wordAddr,
    input  logic [3:0]                byteEn,
    input  logic [`DATA_WIDTH-1:0]    wrData,
    output logic [`DATA_WIDTH-1:0]    rdData
);

    localparam int Depth = 2 ** `RAM_ADDR_BITS;

    logic [`DATA_WIDTH-1:0] mem [Depth];

    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i] = '0;
        end
        rdData = '0;
    end

    // Read returns the contents from before this edge's write.
    always @(posedge clk) begin
        if (readEn) begin
            rdData <= mem[wordAddr];
        end
        for (int b = 0; b < 4; b++) begin
            if (byteEn[b]) begin
                mem[wordAddr][b*8 +: 8] <= wrData[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/memResultSelect.sv */
// Memory result selection.
// Extracts and extends load data, checks load alignment and picks
// the writeback value.

`timescale 1ns/100ps
`default_nettype none

module memResultSelect (
    input  memStagePkg::exeMemPayload stage,
    input  logic [31:0]               rdData,
    output memStagePkg::memWbPayload  result
);

    logic [7:0]             loadByte;
    logic [15:0]            loadHalf;
    logic [31:0]            loadValue;
    logic                   loadMisaligned;
    memStagePkg::exceptCode except;

    assign loadByte = rdData[{stage.aluOut[1:0], 3'b000} +: 8];
    assign loadHalf = stage.aluOut[1] ? rdData[31:16] : rdData[15:0];

    always_comb begin
        loadValue      = rdData;
        loadMisaligned = 1'b0;
        case (stage.load)
            memStagePkg::ldLb: begin
                loadValue = {{24{loadByte[7]}}, loadByte};
            end
            memStagePkg::ldLbu: begin
                loadValue = {24'b0, loadByte};
            end
            memStagePkg::ldLh: begin
                loadValue      = {{16{loadHalf[15]}}, loadHalf};
                loadMisaligned = stage.aluOut[0];
            end
            memStagePkg::ldLhu: begin
                loadValue      = {16'b0, loadHalf};
                loadMisaligned = stage.aluOut[0];
            end
            memStagePkg::ldLw: begin
                loadMisaligned = (stage.aluOut[1:0] != 2'b00);
            end
            default: begin
                loadValue = rdData;
            end
        endcase
    end

    // An earlier exception from execute keeps its code.
    always_comb begin
        except = stage.except;
        if (except == memStagePkg::exNone && loadMisaligned) begin
            except = memStagePkg::exAdel;
        end
    end

    always_comb begin
        result.pc       = stage.pc;
        result.dst      = stage.dst;
        result.except   = except;
        result.regWrite = stage.regWrite && (except == memStagePkg::exNone);
        case (stage.wbSel)
            memStagePkg::selLoad: result.result = loadValue;
            memStagePkg::selLink: result.result = stage.pc + 32'd8;
            default:              result.result = stage.aluOut;
        endcase
    end

endmodule

`default_nettype wire

/* logic/memStage.sv */
// Memory stage of the integer pipeline.
// Store alignment, data RAM and load result selection between the
// execute/memory and memory/writeback stage registers.

`timescale 1ns/100ps
`default_nettype none

`include "memStage_cfg.svh"

module memStage (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`DATA_WIDTH-1:0] exeAluOut,
    input  logic [`DATA_WIDTH-1:0] exeStoreData,
    input  logic [31:0]            exePc,
    input  memStagePkg::loadType   exeLoad,
    input  memStagePkg::storeType  exeStore,
    input  logic [4:0]             exeDst,
    input  logic                   exeRegWrite,
    input  memStagePkg::wbSelType  exeWbSel,
    input  logic                   memWr,
    input  logic                   memFlush,
    output logic [`DATA_WIDTH-1:0] wbResult,
    output logic [31:0]            wbPc,
    output logic [4:0]             wbDst,
    output logic                   wbRegWrite,
    output memStagePkg::exceptCode wbExcept
);

    logic [3:0]                byteEn;
    logic [`DATA_WIDTH-1:0]    ramWrData;
    logic [`DATA_WIDTH-1:0]    ramRdData;
    logic                      storeMisaligned;
    memStagePkg::exeMemPayload exeStage;
    memStagePkg::exeMemPayload memStageQ;
    memStagePkg::memWbPayload  memResult;
    memStagePkg::memWbPayload  wbStage;

    storeAlign storeAlign (
        .addr       (exeAluOut),
        .storeData  (exeStoreData),
        .store      (exeStore),
        .memWr      (memWr),
        .memFlush   (memFlush),
        .byteEn     (byteEn),
        .wrData     (ramWrData),
        .misaligned (storeMisaligned)
    );

    // RAM is addressed from execute so the load data lines up with MEM.
    dataRam dataRam (
        .clk      (clk),
        .readEn   (memWr),
        .wordAddr (exeAluOut[`RAM_ADDR_BITS+1:2]),
        .byteEn   (byteEn),
        .wrData   (ramWrData),
        .rdData   (ramRdData)
    );

    assign exeStage.aluOut   = exeAluOut;
    assign exeStage.pc       = exePc;
    assign exeStage.load     = exeLoad;
    assign exeStage.dst      = exeDst;
    assign exeStage.regWrite = exeRegWrite && !storeMisaligned;
    assign exeStage.wbSel    = exeWbSel;
    assign exeStage.except   = storeMisaligned ? memStagePkg::exAdes : memStagePkg::exNone;

    pipeStageReg #(
        .payloadT (memStagePkg::exeMemPayload)
    ) eMReg (
        .clk     (clk),
        .arstN   (arstN),
        .advance (memWr),
        .flush   (memFlush),
        .d       (exeStage),
        .q       (memStageQ)
    );

    memResultSelect memResultSelect (
        .stage  (memStageQ),
        .rdData (ramRdData),
        .result (memResult)
    );

    // A flush only kills the instruction entering MEM.
    pipeStageReg #(
        .payloadT (memStagePkg::memWbPayload)
    ) mWReg (
        .clk     (clk),
        .arstN   (arstN),
        .advance (memWr),
        .flush   (1'b0),
        .d       (memResult),
        .q       (wbStage)
    );

    assign wbResult   = wbStage.result;
    assign wbPc       = wbStage.pc;
    assign wbDst      = wbStage.dst;
    assign wbRegWrite = wbStage.regWrite;
    assign wbExcept   = wbStage.except;

endmodule

`default_nettype wire

/* logic/memStagePkg.sv */
// Memory stage types.
// Access encodings, exception codes and the two stage payloads.

`default_nettype none

`include "memStage_cfg.svh"

package memStagePkg;

    typedef enum logic [2:0] {
        ldNone,
        ldLb,
        ldLbu,
        ldLh,
        ldLhu,
        ldLw
    } loadType;

    typedef enum logic [1:0] {
        stNone,
        stSb,
        stSh,
        stSw
    } storeType;

    typedef enum logic [1:0] {
        selAlu,
        selLoad,
        selLink
    } wbSelType;

    typedef enum logic [1:0] {
        exNone,
        exAdel,
        exAdes
    } exceptCode;

    // Instruction held between execute and memory.
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] aluOut;
        logic [31:0]            pc;
        loadType                load;
        logic [4:0]             dst;
        logic                   regWrite;
        wbSelType               wbSel;
        exceptCode              except;
    } exeMemPayload;

    // Instruction held between memory and writeback.
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] result;
        logic [31:0]            pc;
        logic [4:0]             dst;
        logic                   regWrite;
        exceptCode              except;
    } memWbPayload;

endpackage

`default_nettype wire

/* logic/pipeStageReg.sv */
// Pipeline stage register.
// Loads the payload on advance, clears on flush, holds otherwise.

`timescale 1ns/100ps
`default_nettype none

module pipeStageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    advance,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Flush wins over advance and leaves a bubble.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (advance) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* logic/storeAlign.sv */
// Store alignment.
// Builds byte enables and lane data for a store and flags a misaligned address.

`timescale 1ns/100ps
`default_nettype none

module storeAlign (
    input  logic [31:0]          addr,
    input  logic [31:0]          storeData,
    input  memStagePkg::storeType store,
    input  logic                 memWr,
    input  logic                 memFlush,
    output logic [3:0]           byteEn,
    output logic [31:0]          wrData,
    output logic                 misaligned
);

    logic [3:0] laneEn;
    logic       writeOk;

    always_comb begin
        laneEn     = 4'b0000;
        wrData     = storeData;
        misaligned = 1'b0;
        case (store)
            memStagePkg::stSb: begin
                laneEn = 4'b0001 << addr[1:0];
                wrData = {4{storeData[7:0]}};
            end
            memStagePkg::stSh: begin
                laneEn     = addr[1] ? 4'b1100 : 4'b0011;
                wrData     = {2{storeData[15:0]}};
                misaligned = addr[0];
            end
            memStagePkg::stSw: begin
                laneEn     = 4'b1111;
                misaligned = (addr[1:0] != 2'b00);
            end
            default: begin
                laneEn = 4'b0000;
            end
        endcase
    end

    // Only a store that really advances into MEM may touch the RAM.
    assign writeOk = memWr && !memFlush && !misaligned;
    assign byteEn  = writeOk ? laneEn : 4'b0000;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the memory stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module memStageTb -o memStageSim

out=$(./obj_dir/memStageSim)
echo "$out"

# The run passes only if the testbench printed its pass line.
echo "$out" | grep -qx "All tests passed"

/* sources.f */
+incdir+include
logic/memStagePkg.sv
logic/pipeStageReg.sv
logic/storeAlign.sv
logic/dataRam.sv
logic/memResultSelect.sv
logic/memStage.sv
verification/memStageTb.sv

/* verification/memStageTb.sv */
// Testbench for the memory stage.
// Random instructions from a fixed seed are checked every cycle against a
// model of the two stage registers and a shadow copy of the data RAM.

`timescale 1ns/100ps
`default_nettype none

`include "memStage_cfg.svh"

module memStageTb;

    localparam int RamWords = 2 ** `RAM_ADDR_BITS;
    localparam logic [31:0] AddrMask = RamWords * 4 - 1;

    logic                   clk;
    logic                   arstN;
    logic [31:0]            exeAluOut;
    logic [31:0]            exeStoreData;
    logic [31:0]            exePc;
    memStagePkg::loadType   exeLoad;
    memStagePkg::storeType  exeStore;
    logic [4:0]             exeDst;
    logic                   exeRegWrite;
    memStagePkg::wbSelType  exeWbSel;
    logic                   memWr;
    logic                   memFlush;
    logic [31:0]            wbResult;
    logic [31:0]            wbPc;
    logic [4:0]             wbDst;
    logic                   wbRegWrite;
    memStagePkg::exceptCode wbExcept;

    logic [31:0]               shadow [RamWords];
    memStagePkg::exeMemPayload modelEm;
    memStagePkg::memWbPayload  modelWb;
    logic [31:0]               modelRd;
    logic [31:0]               rngState;
    int errors;
    int testErrors;
    int checks;
    int testsRun;
    int testsFailed;

    memStage uut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawRandom(output logic [31:0] r);
        rngState = xorshift(rngState);
        r = rngState;
    endtask

    function automatic logic [31:0] extractLoad(input memStagePkg::loadType ld,
                                                input logic [1:0] lane,
                                                input logic [31:0] word);
        logic [31:0] b;
        logic [31:0] h;
        logic [31:0] value;
        b = word >> (8 * lane);
        h = word >> (16 * lane[1]);
        case (ld)
            memStagePkg::ldLb:  value = {{24{b[7]}}, b[7:0]};
            memStagePkg::ldLbu: value = {24'h0, b[7:0]};
            memStagePkg::ldLh:  value = {{16{h[15]}}, h[15:0]};
            memStagePkg::ldLhu: value = {16'h0, h[15:0]};
            default:            value = word;
        endcase
        return value;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            testErrors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkDst(input string name, input logic [4:0] got, input logic [4:0] exp);
        checks++;
        if (got !== exp) begin
            testErrors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            testErrors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkExcept(input string name, input memStagePkg::exceptCode got,
                               input memStagePkg::exceptCode exp);
        checks++;
        if (got !== exp) begin
            testErrors++;
            $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    // One clock edge of the model, using the inputs the DUT samples.
    task automatic modelEdge();
        logic [`RAM_ADDR_BITS-1:0] idx;
        logic [31:0]               mask;
        logic [31:0]               lanes;
        logic [31:0]               wordNow;
        logic                      bad;
        memStagePkg::exceptCode    ex;
        idx = exeAluOut[`RAM_ADDR_BITS+1:2];
        mask = '0;
        lanes = '0;
        bad = 1'b0;
        case (exeStore)
            memStagePkg::stSb: begin
                mask = 32'hff << (8 * exeAluOut[1:0]);
                lanes = {4{exeStoreData[7:0]}};
            end
            memStagePkg::stSh: begin
                mask = 32'hffff << (16 * exeAluOut[1]);
                lanes = {2{exeStoreData[15:0]}};
                bad = exeAluOut[0];
            end
            memStagePkg::stSw: begin
                mask = '1;
                lanes = exeStoreData;
                bad = |exeAluOut[1:0];
            end
            default: mask = '0;
        endcase
        if (memWr) begin
            ex = modelEm.except;
            if (ex == memStagePkg::exNone) begin
                if (((modelEm.load == memStagePkg::ldLh || modelEm.load == memStagePkg::ldLhu)
                     && modelEm.aluOut[0]) ||
                    (modelEm.load == memStagePkg::ldLw && modelEm.aluOut[1:0] != 2'b00)) begin
                    ex = memStagePkg::exAdel;
                end
            end
            modelWb.pc = modelEm.pc;
            modelWb.dst = modelEm.dst;
            modelWb.except = ex;
            modelWb.regWrite = modelEm.regWrite && (ex == memStagePkg::exNone);
            case (modelEm.wbSel)
                memStagePkg::selLoad: modelWb.result = extractLoad(modelEm.load,
                                                                   modelEm.aluOut[1:0], modelRd);
                memStagePkg::selLink: modelWb.result = modelEm.pc + 32'd8;
                default:              modelWb.result = modelEm.aluOut;
            endcase
            wordNow = shadow[idx];
            if (!memFlush && !bad) begin
                shadow[idx] = (wordNow & ~mask) | (lanes & mask);
            end
            modelRd = wordNow;
        end
        if (memFlush) begin
            modelEm = '0;
        end else if (memWr) begin
            modelEm.aluOut = exeAluOut;
            modelEm.pc = exePc;
            modelEm.load = exeLoad;
            modelEm.dst = exeDst;
            modelEm.regWrite = exeRegWrite;
            modelEm.wbSel = exeWbSel;
            modelEm.except = bad ? memStagePkg::exAdes : memStagePkg::exNone;
        end
    endtask

    // Kind 0 is ALU, 1 link, 2 load and 3 store.
    task automatic driveInstr(input int mode, output logic advance);
        logic [31:0]           r0;
        logic [31:0]           r1;
        logic [31:0]           addr;
        logic [1:0]            kind;
        memStagePkg::loadType  ld;
        memStagePkg::storeType st;
        drawRandom(r0);
        drawRandom(r1);
        kind = r0[1:0];
        if (mode == 1) kind = {1'b0, r0[0]};
        if (mode == 2 || mode == 3) kind = {1'b1, r0[0]};
        ld = memStagePkg::loadType'(3'd1 + r0[6:4] % 3'd5);
        st = memStagePkg::storeType'(2'd1 + r0[9:8] % 2'd3);
        addr = r1 & (r0[31] ? AddrMask : 32'h3f);
        if (mode != 3) begin
            if ((kind == 2'd2 && (ld == memStagePkg::ldLh || ld == memStagePkg::ldLhu)) ||
                (kind == 2'd3 && st == memStagePkg::stSh)) addr[0] = 1'b0;
            if ((kind == 2'd2 && ld == memStagePkg::ldLw) ||
                (kind == 2'd3 && st == memStagePkg::stSw)) addr[1:0] = 2'b00;
        end
        advance = (mode == 5) ? (r1[29:28] != 2'b00) : 1'b1;
        exeAluOut <= kind[1] ? addr : r1;
        exeStoreData <= {r1[15:0], r0[31:16]};
        exePc <= (r0 ^ r1) & 32'hffff_fffc;
        exeDst <= r0[14:10];
        exeLoad <= (kind == 2'd2) ? ld : memStagePkg::ldNone;
        exeStore <= (kind == 2'd3) ? st : memStagePkg::stNone;
        exeRegWrite <= (kind != 2'd3);
        exeWbSel <= (kind == 2'd1) ? memStagePkg::selLink :
                    (kind == 2'd2) ? memStagePkg::selLoad : memStagePkg::selAlu;
        memWr <= advance;
        memFlush <= (mode == 4) && (r1[27:25] == 3'b000);
    endtask

    task automatic runTest(input int mode, input string name, input int count);
        int   issued;
        int   cycles;
        logic advanced;
        issued = 0;
        cycles = 0;
        testErrors = 0;
        if (mode == 1) begin
            checkFlag("wbRegWrite", wbRegWrite, 1'b0);
            checkExcept("wbExcept", wbExcept, memStagePkg::exNone);
        end
        while (issued < count && cycles < count * 8) begin
            @(posedge clk);
            modelEdge();
            driveInstr(mode, advanced);
            @(negedge clk);
            checkWord("wbResult", wbResult, modelWb.result);
            checkWord("wbPc", wbPc, modelWb.pc);
            checkDst("wbDst", wbDst, modelWb.dst);
            checkFlag("wbRegWrite", wbRegWrite, modelWb.regWrite);
            checkExcept("wbExcept", wbExcept, modelWb.except);
            cycles++;
            if (advanced) issued++;
        end
        if (issued < count) begin
            testErrors++;
            $display("timeout: test %s advanced only %0d of %0d instructions", name, issued,
                     count);
        end
        testsRun++;
        errors += testErrors;
        if (testErrors != 0) testsFailed++;
        $display("test %0d %s: %s after %0d cycles, %0d errors", mode, name,
                 (testErrors == 0) ? "ok" : "failed", cycles, testErrors);
    endtask

    initial begin
        rngState = 32'he8fd;
        errors = 0;
        testErrors = 0;
        checks = 0;
        testsRun = 0;
        testsFailed = 0;
        clk = 1'b0;
        arstN = 1'b0;
        exeAluOut = '0;
        exeStoreData = '0;
        exePc = '0;
        exeLoad = memStagePkg::ldNone;
        exeStore = memStagePkg::stNone;
        exeDst = '0;
        exeRegWrite = 1'b0;
        exeWbSel = memStagePkg::selAlu;
        memWr = 1'b0;
        memFlush = 1'b0;
        for (int i = 0; i < RamWords; i++) shadow[i] = '0;
        modelEm = '0;
        modelWb = '0;
        modelRd = '0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        runTest(1, "aluAndLink", 40);
        runTest(2, "storeLoad", 300);
        runTest(3, "misaligned", 300);
        runTest(4, "flush", 300);
        runTest(5, "stall", 500);
        $display("tests %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
                 checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
